// ==== build.f ====
hdl/m6502_pkg.sv
hdl/m6502_alu.sv
hdl/m6502_cpu.sv
hdl/mem_arbiter.sv
hdl/sys_ram.sv
hdl/m6502_system.sv
testbench/m6502_system_sva.sv
testbench/tb_m6502_system.sv

// ==== Makefile ====
TOP = tb_m6502_system

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_m6502_system.sv ====
`default_nettype none

module tb_m6502_system import m6502_pkg::*;;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NROWS = 16;
   localparam int TIMEOUT_CYCLES = NROWS * 400;
   localparam logic [ADDR_W-1:0] PROG_BASE   = 16'h0200;
   localparam logic [ADDR_W-1:0] RESULT_ADDR = 16'h0300;
   localparam logic [ADDR_W-1:0] MARKER_ADDR = 16'h02FF;
   localparam logic [DATA_W-1:0] MARKER      = 8'h5A;
   localparam logic [DATA_W-1:0] SENTINEL    = 8'hEE;

   typedef struct packed {
      logic [7:0] opcode;
      addr_mode_e mode;
      logic       idx_y;   // Preset Y instead of X
      logic [7:0] idx;
      logic [7:0] a;
      logic [7:0] m;
      logic [7:0] br;      // Branch after the op, 00 for none
      logic       taken;
      logic [7:0] exp;
   } row_t;

   logic              clk;
   logic              reset_n;
   logic              run_i;
   mem_req_t          host_req;
   logic [DATA_W-1:0] host_rdata;
   logic              host_rvalid;
   logic [ADDR_W-1:0] load_addr;
   int                cycles;
   row_t              rows [NROWS];

   m6502_system dut (
      .clk           (clk),
      .reset_n       (reset_n),
      .run_i         (run_i),
      .host_req_i    (host_req),
      .host_rdata_o  (host_rdata),
      .host_rvalid_o (host_rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES)
      begin
         $display("Timeout: program did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic check_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s = %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s = %b, expected %b", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "handshake mismatch");
      end
   endtask

   task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      host_req.valid = 1'b1;
      host_req.we    = 1'b1;
      host_req.addr  = addr;
      host_req.wdata = data;
      @(posedge clk);
      #1;
      host_req = '0;
   endtask

   task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      host_req.valid = 1'b1;
      host_req.we    = 1'b0;
      host_req.addr  = addr;
      host_req.wdata = '0;
      @(posedge clk);
      #1;
      host_req = '0;
      check_valid(host_rvalid, 1'b1, "host_rvalid_o");
      data = host_rdata;
      @(posedge clk);
      #1;
      check_valid(host_rvalid, 1'b0, "host_rvalid_o");   // Single cycle pulse
   endtask

   task automatic emit_instr(input logic [7:0] opc, input int len, input logic [15:0] opnd);
      host_write(load_addr, opc);
      host_write(load_addr + 16'd1, opnd[7:0]);
      if (len == 3)
         host_write(load_addr + 16'd2, opnd[15:8]);
      load_addr = load_addr + 16'(len);
   endtask

   function automatic logic [ADDR_W-1:0] effective_addr(input row_t r);
      case (r.mode)
         MODE_Z:                 return 16'h0040;
         MODE_Z_X:               return {8'h00, 8'h40 + r.idx};   // Stays in page zero
         MODE_ABS:               return 16'h1234;
         MODE_ABS_X, MODE_ABS_Y: return 16'h12F0 + {8'h00, r.idx};
         MODE_IND_X:             return 16'h2345;
         default:                return 16'h23F0 + {8'h00, r.idx};
      endcase
   endfunction

   function automatic logic [15:0] operand_field(input row_t r);
      case (r.mode)
         MODE_IMM:               return {8'h00, r.m};
         MODE_ABS:               return 16'h1234;
         MODE_ABS_X, MODE_ABS_Y: return 16'h12F0;
         default:                return 16'h0040;
      endcase
   endfunction

   task automatic run_row(input row_t r);
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] probe_data;
      logic [ADDR_W-1:0] probe_addr;
      int                len;
      reset_n = 1'b0;
      run_i   = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset_n = 1'b1;
      check_valid(host_rvalid, 1'b0, "host_rvalid_o");
      probe_addr = {8'h06, 8'($urandom)};
      probe_data = 8'($urandom);
      host_write(probe_addr, probe_data);
      host_read(probe_addr, got);
      check_byte(got, probe_data, "host_rdata_o");
      host_write(RESET_VECTOR, PROG_BASE[7:0]);
      host_write(RESET_VECTOR + 16'd1, PROG_BASE[15:8]);
      host_write(RESULT_ADDR, SENTINEL);
      host_write(MARKER_ADDR, 8'h00);
      if (r.mode == MODE_IND_X)
      begin
         host_write({8'h00, 8'h40 + r.idx}, 8'h45);
         host_write({8'h00, 8'h41 + r.idx}, 8'h23);
      end
      else if (r.mode == MODE_IND_Y)
      begin
         host_write(16'h0040, 8'hF0);
         host_write(16'h0041, 8'h23);
      end
      if (r.mode != MODE_IMM)
         host_write(effective_addr(r), r.m);
      len = (r.mode == MODE_ABS || r.mode == MODE_ABS_X || r.mode == MODE_ABS_Y) ? 3 : 2;
      load_addr = PROG_BASE;
      emit_instr(r.idx_y ? 8'hA0 : 8'hA2, 2, {8'h00, r.idx});
      emit_instr(8'hA9, 2, {8'h00, r.a});
      emit_instr(r.opcode, len, operand_field(r));
      if (r.br != 8'h00)
         emit_instr(r.br, 2, 16'h0003);   // Skips the STA below
      emit_instr(8'h8D, 3, RESULT_ADDR);
      emit_instr(8'hA9, 2, {8'h00, MARKER});
      emit_instr(8'h8D, 3, MARKER_ADDR);
      emit_instr(8'hD0, 2, 16'h00FE);
      run_i = 1'b1;
      got = 8'h00;
      while (got != MARKER)
      begin
         host_write({8'h05, 8'($urandom)}, 8'($urandom));   // Unrelated, stalls the CPU
         host_read(MARKER_ADDR, got);
         repeat (3) @(posedge clk);
         #1;
      end
      host_read(RESULT_ADDR, got);
      check_byte(got, r.taken ? SENTINEL : r.exp, "mem[0300]");
      run_i = 1'b0;
   endtask

   initial begin
      void'($urandom(32'h5bb4));
      reset_n  = 1'b0;
      run_i    = 1'b0;
      host_req = '0;
      cycles   = 0;
      rows[0]  = '{8'hA9, MODE_IMM,   1'b0, 8'h00, 8'h00, 8'h3C, 8'h00, 1'b0, 8'h3C};
      rows[1]  = '{8'h09, MODE_IMM,   1'b0, 8'h00, 8'h0F, 8'hF0, 8'h00, 1'b0, 8'hFF};
      rows[2]  = '{8'h29, MODE_IMM,   1'b0, 8'h00, 8'h3C, 8'h0F, 8'h00, 1'b0, 8'h0C};
      rows[3]  = '{8'h49, MODE_IMM,   1'b0, 8'h00, 8'hFF, 8'h5A, 8'h00, 1'b0, 8'hA5};
      rows[4]  = '{8'h69, MODE_IMM,   1'b0, 8'h00, 8'h7F, 8'h01, 8'h00, 1'b0, 8'h80};
      rows[5]  = '{8'h65, MODE_Z,     1'b0, 8'h00, 8'h12, 8'h34, 8'h00, 1'b0, 8'h46};
      rows[6]  = '{8'hB5, MODE_Z_X,   1'b0, 8'h05, 8'h00, 8'h77, 8'h00, 1'b0, 8'h77};
      rows[7]  = '{8'h0D, MODE_ABS,   1'b1, 8'h00, 8'h01, 8'h80, 8'h00, 1'b0, 8'h81};
      rows[8]  = '{8'h3D, MODE_ABS_X, 1'b0, 8'h20, 8'hFF, 8'hC3, 8'h00, 1'b0, 8'hC3};
      rows[9]  = '{8'h59, MODE_ABS_Y, 1'b1, 8'h11, 8'hAA, 8'h55, 8'h00, 1'b0, 8'hFF};
      rows[10] = '{8'h61, MODE_IND_X, 1'b0, 8'h04, 8'h10, 8'h20, 8'h00, 1'b0, 8'h30};
      rows[11] = '{8'hB1, MODE_IND_Y, 1'b1, 8'h30, 8'h00, 8'h9E, 8'h00, 1'b0, 8'h9E};
      rows[12] = '{8'hC9, MODE_IMM,   1'b0, 8'h00, 8'h42, 8'h42, 8'hF0, 1'b1, 8'h42};
      rows[13] = '{8'hC9, MODE_IMM,   1'b0, 8'h00, 8'h42, 8'h42, 8'hD0, 1'b0, 8'h42};
      rows[14] = '{8'hC5, MODE_Z,     1'b0, 8'h00, 8'h50, 8'h30, 8'hD0, 1'b1, 8'h50};
      rows[15] = '{8'hC9, MODE_IMM,   1'b0, 8'h00, 8'h10, 8'h20, 8'hF0, 1'b0, 8'h10};
      foreach (rows[i])
         run_row(rows[i]);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/m6502_system_sva.sv ====
`default_nettype none

module m6502_system_sva import m6502_pkg::*; (
   input wire logic     clk,
   input wire logic     reset_n,
   input wire mem_req_t host_req_i,
   input wire mem_req_t cpu_req_i,
   input wire logic     cpu_ready_o,
   input wire logic     host_rvalid_o
);

   timeunit 1ns;
   timeprecision 1ps;

   logic host_rd;

   assign host_rd = host_req_i.valid && !host_req_i.we;

   // Refused CPU request stays unchanged for the next cycle
   host_blocks_cpu: assert property (@(posedge clk) disable iff (!reset_n)
      host_req_i.valid && cpu_req_i.valid |=>
         !$past(cpu_ready_o) && cpu_req_i == $past(cpu_req_i))
      else $error("CPU request not refused and held during a host access");

   rvalid_after_read: assert property (@(posedge clk) disable iff (!reset_n)
      host_rd |=> host_rvalid_o)
      else $error("host_rvalid_o missing one cycle after a host read");

   rvalid_needs_read: assert property (@(posedge clk) disable iff (!reset_n)
      host_rvalid_o |-> $past(host_rd))
      else $error("host_rvalid_o without a preceding host read");

endmodule

bind mem_arbiter m6502_system_sva u_arb_sva (
   .clk           (clk),
   .reset_n       (reset_n),
   .host_req_i    (host_req_i),
   .cpu_req_i     (cpu_req_i),
   .cpu_ready_o   (cpu_ready_o),
   .host_rvalid_o (host_rvalid_o)
);

`default_nettype wire

// ==== hdl/m6502_system.sv ====
`default_nettype none

module m6502_system import m6502_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset_n,
   input  wire logic              run_i,
   input  wire mem_req_t          host_req_i,
   output logic      [DATA_W-1:0] host_rdata_o,
   output logic                   host_rvalid_o
);

   mem_req_t          cpu_req;
   mem_req_t          ram_req;
   logic              cpu_ready;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] ram_rdata;

   m6502_cpu u_cpu (
      .clk       (clk),
      .reset_n   (reset_n),
      .run_i     (run_i),
      .ready_i   (cpu_ready),
      .rd_data_i (rd_data),
      .mem_req_o (cpu_req)
   );

   mem_arbiter u_arbiter (
      .clk           (clk),
      .reset_n       (reset_n),
      .host_req_i    (host_req_i),
      .cpu_req_i     (cpu_req),
      .cpu_ready_o   (cpu_ready),
      .ram_req_o     (ram_req),
      .ram_rdata_i   (ram_rdata),
      .cpu_rdata_o   (rd_data),
      .host_rdata_o  (host_rdata_o),
      .host_rvalid_o (host_rvalid_o)
   );

   sys_ram u_ram (
      .clk     (clk),
      .req_i   (ram_req),
      .rdata_o (ram_rdata)
   );

endmodule

`default_nettype wire

// ==== hdl/sys_ram.sv ====
`default_nettype none

module sys_ram import m6502_pkg::*; (
   input  wire logic              clk,
   input  wire mem_req_t          req_i,
   output logic      [DATA_W-1:0] rdata_o
);

   logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

   always_ff @(posedge clk) begin
      if (req_i.valid)
      begin
         if (req_i.we)
            mem[req_i.addr] <= req_i.wdata;
         else
            rdata_o <= mem[req_i.addr];   // One cycle read latency
      end
   end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import m6502_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset_n,
   input  wire mem_req_t          host_req_i,
   input  wire mem_req_t          cpu_req_i,
   output logic                   cpu_ready_o,
   output mem_req_t               ram_req_o,
   input  wire logic [DATA_W-1:0] ram_rdata_i,
   output logic      [DATA_W-1:0] cpu_rdata_o,
   output logic      [DATA_W-1:0] host_rdata_o,
   output logic                   host_rvalid_o
);

   logic host_rd_q;
   logic cpu_rd_q;

   // Host always wins, the CPU just waits
   assign cpu_ready_o = !host_req_i.valid;
   assign ram_req_o   = host_req_i.valid ? host_req_i : cpu_req_i;

   always_ff @(posedge clk) begin
      if (!reset_n)
      begin
         host_rd_q <= 1'b0;
         cpu_rd_q  <= 1'b0;
      end
      else
      begin
         host_rd_q <= host_req_i.valid && !host_req_i.we;
         cpu_rd_q  <= !host_req_i.valid && cpu_req_i.valid && !cpu_req_i.we;
      end
   end

   assign host_rvalid_o = host_rd_q;
   assign host_rdata_o  = host_rd_q ? ram_rdata_i : '0;
   assign cpu_rdata_o   = cpu_rd_q ? ram_rdata_i : '0;

endmodule

`default_nettype wire

// ==== hdl/m6502_cpu.sv ====
`default_nettype none

module m6502_cpu import m6502_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset_n,
   input  wire logic              run_i,
   input  wire logic              ready_i,
   input  wire logic [DATA_W-1:0] rd_data_i,
   output mem_req_t               mem_req_o
);

   cpu_state_e        state;
   seq_step_e         step;
   logic [ADDR_W-1:0] pc;
   logic [DATA_W-1:0] ir, a, x, y, tmp, ptr;
   logic              done, rd_pend, stall;
   addr_mode_e        mode;
   alu_op_e           op;
   dest_e             dest;
   logic              is_store, is_branch, take;
   logic [1:0]        pc_len;
   logic [ADDR_W-1:0] pc_adv, ea;
   logic [DATA_W-1:0] idx, zp_sum, zp_ptr;
   mem_req_t          final_req;
   logic              alu_proceed;
   logic [DATA_W-1:0] alu_out;
   alu_flags_t        flags;

   function automatic mem_req_t rd_req(input logic [ADDR_W-1:0] addr);
      mem_req_t req;
      req.valid = 1'b1;
      req.we    = 1'b0;
      req.addr  = addr;
      req.wdata = '0;
      return req;
   endfunction

   // Opcode layout aaabbbcc
   always_comb begin
      mode      = MODE_SINGLE;
      op        = OP_UPDATE;
      dest      = DST_NONE;
      is_store  = 1'b0;
      is_branch = 1'b0;
      case (ir[1:0])
         2'b01:
            if (ir[7:5] != 3'b111)
            begin
               case (ir[4:2])
                  3'd0: mode = MODE_IND_X;
                  3'd1: mode = MODE_Z;
                  3'd2: mode = MODE_IMM;
                  3'd3: mode = MODE_ABS;
                  3'd4: mode = MODE_IND_Y;
                  3'd5: mode = MODE_Z_X;
                  3'd6: mode = MODE_ABS_Y;
                  default: mode = MODE_ABS_X;
               endcase
               dest = DST_A;
               case (ir[7:5])
                  3'b000: op = OP_OR;
                  3'b001: op = OP_AND;
                  3'b010: op = OP_EOR;
                  3'b011: op = OP_ADC;
                  3'b101: op = OP_UPDATE;   // LDA
                  3'b100:
                  begin
                     is_store = 1'b1;
                     dest     = DST_NONE;
                  end
                  default:
                  begin
                     op   = OP_CMP;
                     dest = DST_NONE;
                  end
               endcase
            end
         2'b00:
            if (ir[4:0] == 5'b10000)
            begin
               mode      = MODE_IMM;
               is_branch = 1'b1;
            end
            else if (ir == 8'hA0)
            begin
               mode = MODE_IMM;
               dest = DST_Y;
            end
         2'b10:
            if (ir == 8'hA2)
            begin
               mode = MODE_IMM;
               dest = DST_X;
            end
         default: ;
      endcase
      case (mode)
         MODE_SINGLE: pc_len = 2'd1;
         MODE_ABS, MODE_ABS_X, MODE_ABS_Y: pc_len = 2'd3;
         default: pc_len = 2'd2;
      endcase
   end

   // Flag picked by ir[7:6], compared against ir[5]
   always_comb begin
      case (ir[7:6])
         2'b00:   take = (flags.n == ir[5]);
         2'b01:   take = (flags.v == ir[5]);
         2'b10:   take = (flags.c == ir[5]);
         default: take = (flags.z == ir[5]);
      endcase
   end

   assign idx = (mode == MODE_Z_X || mode == MODE_ABS_X || mode == MODE_IND_X) ? x :
                (mode == MODE_ABS_Y || mode == MODE_IND_Y) ? y : 8'h00;
   assign zp_sum = rd_data_i + idx;   // Wraps inside page zero
   assign zp_ptr = (mode == MODE_IND_X) ? zp_sum : rd_data_i;
   assign ea     = (step == SEQ_OPND) ? {8'h00, zp_sum} :
                   {rd_data_i, tmp} + {8'h00, (mode == MODE_IND_X) ? 8'h00 : idx};
   assign pc_adv = pc + {14'd0, pc_len};
   assign stall  = mem_req_o.valid && !ready_i;

   always_comb begin
      final_req = rd_req(ea);
      if (is_store)
      begin
         final_req.we    = 1'b1;
         final_req.wdata = a;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n)
         rd_pend <= 1'b0;
      else
         rd_pend <= mem_req_o.valid && ready_i && !mem_req_o.we;
   end

   always_ff @(posedge clk) begin
      if (!reset_n)
      begin
         state     <= ST_WAIT;
         step      <= SEQ_IDLE;
         mem_req_o <= '0;
         done      <= 1'b0;
      end
      else if (!stall)
      begin
         if (mem_req_o.valid)
            mem_req_o.valid <= 1'b0;   // Accepted this cycle
         case (state)
            ST_WAIT:
               if (run_i)
                  state <= ST_RESET;
            ST_RESET:
            begin
               a         <= '0;
               x         <= '0;
               y         <= '0;
               mem_req_o <= rd_req(RESET_VECTOR);
               step      <= SEQ_VEC_LO;
               state     <= ST_EXEC_WAIT;
            end
            ST_FETCH:
               if (rd_pend)
               begin
                  ir    <= rd_data_i;
                  state <= ST_EXEC;
               end
            ST_EXEC:
            begin
               if (mode == MODE_SINGLE)
               begin
                  pc   <= pc_adv;
                  done <= 1'b1;
               end
               else
               begin
                  mem_req_o <= rd_req(pc + 16'd1);
                  step      <= (mode == MODE_IMM) ? SEQ_DATA : SEQ_OPND;
               end
               state <= ST_EXEC_WAIT;
            end
            default:
               if (done)
               begin
                  done      <= 1'b0;
                  mem_req_o <= rd_req(pc);
                  state     <= ST_FETCH;
               end
         endcase
         case (step)
            SEQ_VEC_LO:
               if (rd_pend)
               begin
                  tmp       <= rd_data_i;
                  mem_req_o <= rd_req(RESET_VECTOR + 16'd1);
                  step      <= SEQ_VEC_HI;
               end
            SEQ_VEC_HI:
               if (rd_pend)
               begin
                  pc   <= {rd_data_i, tmp};
                  done <= 1'b1;
                  step <= SEQ_IDLE;
               end
            SEQ_OPND:
               if (rd_pend)
                  case (mode)
                     MODE_Z, MODE_Z_X:
                     begin
                        mem_req_o <= final_req;
                        step      <= is_store ? SEQ_STORE : SEQ_DATA;
                     end
                     MODE_IND_X, MODE_IND_Y:
                     begin
                        ptr       <= zp_ptr;
                        mem_req_o <= rd_req({8'h00, zp_ptr});
                        step      <= SEQ_PTR_LO;
                     end
                     default:
                     begin
                        tmp       <= rd_data_i;
                        mem_req_o <= rd_req(pc + 16'd2);
                        step      <= SEQ_ABS_HI;
                     end
                  endcase
            SEQ_PTR_LO:
               if (rd_pend)
               begin
                  tmp       <= rd_data_i;
                  mem_req_o <= rd_req({8'h00, ptr + 8'd1});
                  step      <= SEQ_PTR_HI;
               end
            SEQ_ABS_HI, SEQ_PTR_HI:
               if (rd_pend)
               begin
                  mem_req_o <= final_req;
                  step      <= is_store ? SEQ_STORE : SEQ_DATA;
               end
            SEQ_DATA:
               if (rd_pend && is_branch)
               begin
                  pc   <= pc + 16'd2 + (take ? {{8{rd_data_i[7]}}, rd_data_i} : 16'd0);
                  done <= 1'b1;
                  step <= SEQ_IDLE;
               end
               else if (rd_pend)
                  step <= SEQ_WB;   // ALU registers this cycle
            SEQ_WB:
            begin
               case (dest)
                  DST_A: a <= alu_out;
                  DST_X: x <= alu_out;
                  DST_Y: y <= alu_out;
                  default: ;
               endcase
               pc   <= pc_adv;
               done <= 1'b1;
               step <= SEQ_IDLE;
            end
            SEQ_STORE:
               if (mem_req_o.valid)
               begin
                  pc   <= pc_adv;
                  done <= 1'b1;
                  step <= SEQ_IDLE;
               end
            default: ;
         endcase
      end
   end

   assign alu_proceed = rd_pend && step == SEQ_DATA && !is_branch;

   m6502_alu u_alu (
      .clk       (clk),
      .reset_n   (reset_n),
      .proceed_i (alu_proceed),
      .op_i      (op),
      .in_a_i    ((op == OP_UPDATE) ? rd_data_i : a),
      .in_b_i    (rd_data_i),
      .out_o     (alu_out),
      .flags_o   (flags)
   );

endmodule

`default_nettype wire

// ==== hdl/m6502_alu.sv ====
`default_nettype none

module m6502_alu import m6502_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset_n,
   input  wire logic              proceed_i,
   input  wire alu_op_e           op_i,
   input  wire logic [DATA_W-1:0] in_a_i,
   input  wire logic [DATA_W-1:0] in_b_i,
   output logic      [DATA_W-1:0] out_o,
   output alu_flags_t             flags_o
);

   logic [DATA_W-1:0] b_eff;
   logic              carry_in;
   logic [DATA_W:0]   sum;
   logic [DATA_W-1:0] result;
   logic              ovf;

   // CMP subtracts as a plus not b plus one
   assign b_eff    = (op_i == OP_CMP) ? ~in_b_i : in_b_i;
   assign carry_in = (op_i == OP_CMP) ? 1'b1 : flags_o.c;
   assign sum      = {1'b0, in_a_i} + {1'b0, b_eff} + {{DATA_W{1'b0}}, carry_in};
   assign ovf      = (in_a_i[7] == in_b_i[7]) && (sum[7] != in_a_i[7]);

   always_comb begin
      case (op_i)
         OP_OR:   result = in_a_i | in_b_i;
         OP_AND:  result = in_a_i & in_b_i;
         OP_EOR:  result = in_a_i ^ in_b_i;
         OP_ADC,
         OP_CMP:  result = sum[DATA_W-1:0];
         default: result = in_a_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (proceed_i && op_i != OP_CMP)
         out_o <= result;   // CMP keeps the last result
   end

   always_ff @(posedge clk) begin
      if (!reset_n)
         flags_o <= '0;
      else if (proceed_i)
      begin
         flags_o.n <= result[7];
         flags_o.z <= (result == '0);
         if (op_i == OP_ADC)
         begin
            flags_o.c <= sum[DATA_W];
            flags_o.v <= ovf;
         end
         else if (op_i == OP_CMP)
            flags_o.c <= sum[DATA_W];   // Set when a >= b
      end
   end

endmodule

`default_nettype wire

// ==== hdl/m6502_pkg.sv ====
`default_nettype none

package m6502_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;
   localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;

   typedef enum logic [2:0] {
      OP_UPDATE,
      OP_OR,
      OP_AND,
      OP_EOR,
      OP_ADC,
      OP_CMP
   } alu_op_e;

   typedef enum logic [3:0] {
      MODE_IDLE,
      MODE_RESET,
      MODE_SINGLE,
      MODE_IMM,
      MODE_Z,
      MODE_Z_X,
      MODE_ABS,
      MODE_ABS_X,
      MODE_ABS_Y,
      MODE_IND_X,
      MODE_IND_Y
   } addr_mode_e;

   typedef enum logic [2:0] {ST_WAIT, ST_RESET, ST_FETCH, ST_EXEC, ST_EXEC_WAIT} cpu_state_e;

   // Address sequencer steps, each one waits for a returned byte
   typedef enum logic [3:0] {
      SEQ_IDLE, SEQ_VEC_LO, SEQ_VEC_HI, SEQ_OPND, SEQ_ABS_HI,
      SEQ_PTR_LO, SEQ_PTR_HI, SEQ_DATA, SEQ_WB, SEQ_STORE
   } seq_step_e;

   typedef enum logic [1:0] {DST_NONE, DST_A, DST_X, DST_Y} dest_e;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } alu_flags_t;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

endpackage

`default_nettype wire
